//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
LINTFLAGS = --lint-only -Wall --timing
TOP      = aesEncCoreTb
FILELIST = aesEncCore.f
BUILDDIR = obj_dir
PASSMSG  = Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(BUILDDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASSMSG)"

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILDDIR)

//--- aesEncCore.f
+incdir+src
+incdir+dv
src/aesTypesPkg.sv
src/aesCtrlPkg.sv
src/aesSbox.sv
src/aesRoundDatapath.sv
src/aesRoundCtrl.sv
src/aesEncCore.sv
dv/aesEncCoreTb.sv

//--- dv/aesModel.svh
`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

////////////////////////////////////////////////////////////
// FIPS-197 AES-256 reference, included in the testbench body
////////////////////////////////////////////////////////////

// field product, shift and add over the multiplier bits
function automatic aesByte gfProduct(input aesByte a, input aesByte b);
    aesByte p;
    aesByte x;
    aesByte y;
    p = 8'h00;
    x = a;
    y = b;
    while (y != 8'h00) begin
        if (y[0]) begin
            p = p ^ x;
        end
        x = x[7] ? ((x << 1) ^ `AES_POLY) : (x << 1);
        y = y >> 1;
    end
    return p;
endfunction

// inverse found by search, then the bit formula of the affine step
function automatic aesByte sboxByte(input aesByte x);
    aesByte inv;
    aesByte s;
    aesByte c;
    inv = 8'h00;
    c = `AES_AFFINE_C;
    for (int b = 1; b < 256; b++) begin
        if (gfProduct(x, aesByte'(b)) == 8'h01) begin
            inv = aesByte'(b);
        end
    end
    for (int i = 0; i < 8; i++) begin
        s[i] = inv[i] ^ inv[(i+4)%8] ^ inv[(i+5)%8] ^ inv[(i+6)%8] ^ inv[(i+7)%8] ^ c[i];
    end
    return s;
endfunction

function automatic aesWord subWord(input aesWord w);
    return {sboxByte(w[31:24]), sboxByte(w[23:16]), sboxByte(w[15:8]), sboxByte(w[7:0])};
endfunction

// Nk = 8 schedule, word 0 at the top of the result
function automatic aesKeySched expandKey(input logic [255:0] key);
    aesWord w [`AES_KEY_WORDS];
    aesWord temp;
    aesByte rcon;
    aesKeySched sched;
    rcon = 8'h01;
    for (int i = 0; i < 8; i++) begin
        w[i] = key[255-32*i -: 32];
    end
    for (int i = 8; i < `AES_KEY_WORDS; i++) begin
        temp = w[i-1];
        if (i % 8 == 0) begin
            temp = subWord({temp[23:0], temp[31:24]}) ^ {rcon, 24'h000000};
            rcon = gfProduct(rcon, 8'h02);
        end else if (i % 8 == 4) begin
            temp = subWord(temp);
        end
        w[i] = w[i-8] ^ temp;
    end
    for (int i = 0; i < `AES_KEY_WORDS; i++) begin
        sched[`AES_KEY_WORDS*32-1-32*i -: 32] = w[i];
    end
    return sched;
endfunction

// state kept as bytes, index 4*column + row
function automatic aesBlock encryptBlock(input aesBlock plain, input aesKeySched sched);
    aesByte st [16];
    aesByte tmp [16];
    aesWord rk;
    aesBlock result;
    for (int i = 0; i < 16; i++) begin
        st[i] = plain[127-8*i -: 8];
    end
    for (int rnd = 0; rnd <= `AES_NR; rnd++) begin
        if (rnd > 0) begin
            for (int i = 0; i < 16; i++) begin
                tmp[i] = sboxByte(st[i]);
            end
            for (int i = 0; i < 16; i++) begin
                st[i] = tmp[4*((i/4 + i%4) % 4) + i%4];
            end
            if (rnd < `AES_NR) begin
                for (int c = 0; c < 4; c++) begin
                    for (int r = 0; r < 4; r++) begin
                        tmp[4*c+r] = gfProduct(8'h02, st[4*c+r]) ^ gfProduct(8'h03, st[4*c+(r+1)%4])
                                   ^ st[4*c+(r+2)%4] ^ st[4*c+(r+3)%4];
                    end
                end
                st = tmp;
            end
        end
        for (int c = 0; c < 4; c++) begin
            rk = sched[`AES_KEY_WORDS*32-1-32*(4*rnd+c) -: 32];
            for (int r = 0; r < 4; r++) begin
                st[4*c+r] = st[4*c+r] ^ rk[31-8*r -: 8];
            end
        end
    end
    for (int i = 0; i < 16; i++) begin
        result[127-8*i -: 8] = st[i];
    end
    return result;
endfunction

`endif

//--- dv/aesEncCoreTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "aesDefs.svh"

module aesEncCoreTb;

    import aesTypesPkg::*;

    `include "aesModel.svh"

    // about 12 encryptions of 17 cycles plus reset and margin
    localparam int timeoutCycles = 2000;
    localparam int doneLimit = 4 * (`AES_NR + 3);

    logic       clk;
    logic       rst;
    logic       start;
    aesKeySched keyIn;
    aesBlock    dataIn;
    logic       busy;
    logic       encDone;
    aesBlock    cipher;

    int          cycleCount = 0;
    int          checkCount;
    int          errCount;
    logic [31:0] lcgState;

    aesEncCore uut (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .keyIn   (keyIn),
        .dataIn  (dataIn),
        .busy    (busy),
        .encDone (encDone),
        .cipher  (cipher)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // hard stop for a stuck run
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("run stopped: still going after %0d cycles", timeoutCycles);
            $display("checks: %0d, errors: %0d", checkCount, errCount + 1);
            $display("Verification failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic aesBlock randomBlock();
        aesBlock b;
        for (int i = 0; i < 4; i++) begin
            b[127-32*i -: 32] = nextRandom();
        end
        return b;
    endfunction

    task automatic checkValue(input string testName, input logic [127:0] expected,
                              input logic [127:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errCount++;
            $display("ERR %s: expected %0h, actual %0h", testName, expected, actual);
        end
    endtask

    // returns just after the accepting edge
    task automatic startBlock(input aesBlock block, input aesKeySched sched);
        @(posedge clk);
        keyIn  <= sched;
        dataIn <= block;
        start  <= 1'b1;
        @(posedge clk);
        start  <= 1'b0;
    endtask

    // edges counts clock edges after the accepting one
    task automatic waitDone(input string testName, output int edges);
        edges = 0;
        @(negedge clk);
        while (!encDone && edges < doneLimit) begin
            edges++;
            @(negedge clk);
        end
        if (!encDone) begin
            errCount++;
            $display("%s: no done pulse within %0d cycles of the start", testName, doneLimit);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic inspectResetState();
        @(negedge clk);
        checkValue("reset busy", 128'(0), 128'(busy));
        checkValue("reset done", 128'(0), 128'(encDone));
        checkValue("reset cipher", 128'(0), cipher);
    endtask

    task automatic encryptStandardVector();
        aesKeySched sched;
        aesBlock    expected;
        aesBlock    plain;
        int         edges;
        sched    = expandKey(256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f);
        plain    = 128'h00112233445566778899aabbccddeeff;
        expected = 128'h8ea2b7ca516745bfeafc49904b496089;
        checkValue("standard vector model", expected, encryptBlock(plain, sched));
        startBlock(plain, sched);
        waitDone("standard vector", edges);
        checkValue("standard vector latency", 128'(`AES_NR + 1), 128'(edges));
        checkValue("standard vector", expected, cipher);
    endtask

    task automatic measureLatency();
        aesKeySched sched;
        aesBlock    plain;
        sched = expandKey({randomBlock(), randomBlock()});
        plain = randomBlock();
        startBlock(plain, sched);
        // sample once per cycle after edge n
        for (int n = 0; n <= `AES_NR + 1; n++) begin
            @(negedge clk);
            checkValue("latency busy", 128'(n < `AES_NR + 1), 128'(busy));
            checkValue("latency done", 128'(n == `AES_NR + 1), 128'(encDone));
        end
        @(negedge clk);
        checkValue("latency done width", 128'(0), 128'(encDone));
        checkValue("latency cipher", encryptBlock(plain, sched), cipher);
    endtask

    task automatic encryptRandomBlocks();
        aesKeySched sched;
        aesBlock    plain;
        int         edges;
        for (int k = 0; k < 6; k++) begin
            sched = expandKey({randomBlock(), randomBlock()});
            plain = randomBlock();
            startBlock(plain, sched);
            waitDone($sformatf("random block %0d", k), edges);
            checkValue($sformatf("random latency %0d", k), 128'(`AES_NR + 1), 128'(edges));
            checkValue($sformatf("random block %0d", k), encryptBlock(plain, sched), cipher);
        end
    endtask

    task automatic pulseStartWhileBusy();
        aesKeySched sched;
        aesBlock    plainA;
        aesBlock    plainB;
        int         edges;
        sched  = expandKey({randomBlock(), randomBlock()});
        plainA = randomBlock();
        plainB = randomBlock();
        startBlock(plainA, sched);
        repeat (3) @(posedge clk);
        // second start lands mid encryption
        start  <= 1'b1;
        dataIn <= plainB;
        @(posedge clk);
        start  <= 1'b0;
        waitDone("ignored start", edges);
        // done still due at edge 15 of the first block
        checkValue("ignored start latency", 128'(`AES_NR + 1 - 4), 128'(edges));
        checkValue("ignored start", encryptBlock(plainA, sched), cipher);
    endtask

    task automatic runBackToBack();
        aesKeySched schedA;
        aesKeySched schedB;
        aesBlock    plainA;
        aesBlock    plainB;
        int         edges;
        schedA = expandKey({randomBlock(), randomBlock()});
        schedB = expandKey({randomBlock(), randomBlock()});
        plainA = randomBlock();
        plainB = randomBlock();
        startBlock(plainA, schedA);
        // start is seen at edge 16 in the done cycle
        repeat (`AES_NR + 1) @(posedge clk);
        keyIn  <= schedB;
        dataIn <= plainB;
        start  <= 1'b1;
        @(negedge clk);
        checkValue("back to back first done", 128'(1), 128'(encDone));
        checkValue("back to back first cipher", encryptBlock(plainA, schedA), cipher);
        @(posedge clk);
        start  <= 1'b0;
        @(negedge clk);
        checkValue("back to back accepted", 128'(1), 128'(busy));
        waitDone("back to back", edges);
        // counting starts one edge late after the busy sample
        checkValue("back to back latency", 128'(`AES_NR), 128'(edges));
        checkValue("back to back second cipher", encryptBlock(plainB, schedB), cipher);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst        = 1'b0;
        start      = 1'b0;
        keyIn      = '0;
        dataIn     = '0;
        lcgState   = 32'h2c4c;
        checkCount = 0;
        errCount   = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b1;
        inspectResetState();
        encryptStandardVector();
        measureLatency();
        encryptRandomBlocks();
        pulseStartWhileBusy();
        runBackToBack();
        @(posedge clk);
        $display("checks: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/aesCtrlPkg.sv
`default_nettype none

package aesCtrlPkg;

    // sequencer states
    typedef enum logic [1:0] {seqIdle, seqRound, seqFinish} aesSeqState;

    // round number, 0 for the initial key add up to 14
    typedef logic [3:0] aesRoundIdx;

endpackage

`default_nettype wire

//--- src/aesDefs.svh
`ifndef AES_DEFS_SVH
`define AES_DEFS_SVH

// block and key schedule geometry for AES-256
`define AES_NB          4
`define AES_NR          14
`define AES_KEY_WORDS   60
`define AES_BLOCK_BITS  128

// GF(2^8) reduction byte, x^8 + x^4 + x^3 + x + 1 without the top bit
`define AES_POLY        8'h1b

// constant added after the S-box affine mix
`define AES_AFFINE_C    8'h63

`endif

//--- src/aesEncCore.sv
`timescale 1ns/100ps
`default_nettype none

module aesEncCore (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     start,
    input  aesTypesPkg::aesKeySched keyIn,
    input  aesTypesPkg::aesBlock    dataIn,
    output logic                    busy,
    output logic                    encDone,
    output aesTypesPkg::aesBlock    cipher
);

    import aesTypesPkg::*;

    logic    loadBlock;
    logic    advance;
    logic    lastRound;
    aesBlock roundKey;

    // sequencer and key select
    aesRoundCtrl ctrl (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .keyIn     (keyIn),
        .loadBlock (loadBlock),
        .advance   (advance),
        .lastRound (lastRound),
        .roundKey  (roundKey),
        .busy      (busy),
        .encDone   (encDone)
    );

    // state register and round logic, result held until next load
    aesRoundDatapath datapath (
        .clk       (clk),
        .rst       (rst),
        .dataIn    (dataIn),
        .loadBlock (loadBlock),
        .advance   (advance),
        .lastRound (lastRound),
        .roundKey  (roundKey),
        .stateOut  (cipher)
    );

endmodule

`default_nettype wire

//--- src/aesRoundCtrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "aesDefs.svh"

module aesRoundCtrl (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     start,
    input  aesTypesPkg::aesKeySched keyIn,
    output logic                    loadBlock,
    output logic                    advance,
    output logic                    lastRound,
    output aesTypesPkg::aesBlock    roundKey,
    output logic                    busy,
    output logic                    encDone
);

    import aesCtrlPkg::*;

    aesSeqState state;
    aesSeqState nextState;
    aesRoundIdx roundIdx;

    ////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////

    // start is only taken while idle
    assign loadBlock = start && (state == seqIdle);
    assign advance   = (state == seqRound);
    assign lastRound = (roundIdx == aesRoundIdx'(`AES_NR));
    assign busy      = (state != seqIdle);

    always_comb begin
        nextState = state;
        case (state)
            seqIdle: begin
                if (start) begin
                    nextState = seqRound;
                end
            end
            seqRound: begin
                if (lastRound) begin
                    nextState = seqFinish;
                end
            end
            seqFinish: begin
                nextState = seqIdle;
            end
            default: begin
                nextState = seqIdle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state    <= seqIdle;
            roundIdx <= '0;
            encDone  <= 1'b0;
        end else begin
            state   <= nextState;
            // one cycle pulse on the way back to idle
            encDone <= (state == seqFinish);
            if (loadBlock) begin
                roundIdx <= aesRoundIdx'(1);
            end else if (advance) begin
                // back to 0 after the last round so idle picks words 0..3
                roundIdx <= lastRound ? '0 : roundIdx + aesRoundIdx'(1);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // round key select
    ////////////////////////////////////////////////////////////

    // words 4r .. 4r+3, word 0 at the top of keyIn
    assign roundKey =
        keyIn[`AES_KEY_WORDS*32-1 - roundIdx*(`AES_NB*32) -: `AES_NB*32];

endmodule

`default_nettype wire

//--- src/aesRoundDatapath.sv
`timescale 1ns/100ps
`default_nettype none

`include "aesDefs.svh"

module aesRoundDatapath (
    input  wire                  clk,
    input  wire                  rst,
    input  aesTypesPkg::aesBlock dataIn,
    input  wire                  loadBlock,
    input  wire                  advance,
    input  wire                  lastRound,
    input  aesTypesPkg::aesBlock roundKey,
    output aesTypesPkg::aesBlock stateOut
);

    import aesTypesPkg::*;

    // multiply by x in the field
    function automatic aesByte xtime(input aesByte b);
        return {b[6:0], 1'b0} ^ (b[7] ? `AES_POLY : 8'h00);
    endfunction

    // one column through the fixed 02 03 01 01 matrix
    function automatic aesWord mixColumn(input aesWord col);
        aesByte a0;
        aesByte a1;
        aesByte a2;
        aesByte a3;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        // 03*a is xtime(a) ^ a
        return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
    endfunction

    aesBlock stateReg;
    aesByte  subBytes [`AES_NB*4];
    aesBlock shiftedBlock;
    aesBlock mixedBlock;
    aesBlock roundOut;

    ////////////////////////////////////////////////////////////
    // SubBytes
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `AES_NB*4; i++) begin : genSbox
        aesSbox sboxInst (
            .inByte  (stateReg[`AES_NB*32-1-8*i -: 8]),
            .outByte (subBytes[i])
        );
    end

    ////////////////////////////////////////////////////////////
    // ShiftRows and MixColumns per column
    ////////////////////////////////////////////////////////////

    for (genvar c = 0; c < `AES_NB; c++) begin : genCol
        // row r rotates left by r columns
        for (genvar r = 0; r < 4; r++) begin : genRow
            assign shiftedBlock[`AES_NB*32-1-32*c-8*r -: 8] =
                subBytes[4*((c+r)%`AES_NB)+r];
        end
        assign mixedBlock[`AES_NB*32-1-32*c -: 32] =
            mixColumn(shiftedBlock[`AES_NB*32-1-32*c -: 32]);
    end

    // final round skips the column mix
    assign roundOut = (lastRound ? shiftedBlock : mixedBlock) ^ roundKey;

    ////////////////////////////////////////////////////////////
    // state register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            stateReg <= '0;
        end else if (loadBlock) begin
            // initial AddRoundKey
            stateReg <= dataIn ^ roundKey;
        end else if (advance) begin
            stateReg <= roundOut;
        end
    end

    assign stateOut = stateReg;

endmodule

`default_nettype wire

//--- src/aesSbox.sv
`timescale 1ns/100ps
`default_nettype none

`include "aesDefs.svh"

module aesSbox (
    input  aesTypesPkg::aesByte inByte,
    output aesTypesPkg::aesByte outByte
);

    import aesTypesPkg::*;

    ////////////////////////////////////////////////////////////
    // field arithmetic
    ////////////////////////////////////////////////////////////

    // shift and add multiply, reduced on every shift
    function automatic aesByte gfMul(input aesByte a, input aesByte b);
        aesByte acc;
        aesByte sh;
        acc = '0;
        sh = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ sh;
            end
            sh = {sh[6:0], 1'b0} ^ (sh[7] ? `AES_POLY : 8'h00);
        end
        return acc;
    endfunction

    // inverse as x^254, msb first square and multiply
    // zero stays zero since every multiply by x clears it
    function automatic aesByte gfInv(input aesByte x);
        aesByte acc;
        aesByte expo;
        acc = 8'h01;
        expo = 8'hfe;
        for (int i = 7; i >= 0; i--) begin
            acc = gfMul(acc, acc);
            if (expo[i]) begin
                acc = gfMul(acc, x);
            end
        end
        return acc;
    endfunction

    ////////////////////////////////////////////////////////////
    // affine transform
    ////////////////////////////////////////////////////////////

    aesByte inv;

    assign inv = gfInv(inByte);

    // bit i picks up bits i+4 .. i+7, which are the left rotations by 1 to 4
    assign outByte = inv
                   ^ {inv[6:0], inv[7]}
                   ^ {inv[5:0], inv[7:6]}
                   ^ {inv[4:0], inv[7:5]}
                   ^ {inv[3:0], inv[7:4]}
                   ^ `AES_AFFINE_C;

endmodule

`default_nettype wire

//--- src/aesTypesPkg.sv
`default_nettype none

`include "aesDefs.svh"

package aesTypesPkg;

    // single state or key byte
    typedef logic [7:0] aesByte;

    // one column of the state, or one schedule word
    typedef logic [`AES_BLOCK_BITS/`AES_NB-1:0] aesWord;

    // full state, byte 0 sits in the top bits
    typedef logic [`AES_BLOCK_BITS-1:0] aesBlock;

    // expanded schedule, word 0 sits in the top bits
    typedef logic [`AES_KEY_WORDS*32-1:0] aesKeySched;

endpackage

`default_nettype wire
